// ==== include/mrd_cfg.svh ====
`ifndef MRD_CFG_SVH
`define MRD_CFG_SVH

// memory organisation
// seven banks, so no power-of-two stride folds onto one bank
`define MRD_NUM_BANKS 7

// lanes per butterfly, sized for radix 5
`define MRD_NUM_LANES 5

// real and imaginary part width
`define MRD_DATA_W 18

// sample address, up to 4096 points
`define MRD_ADDR_W 12

// bank row address and depth
// 586 rows x 7 banks covers 4096 points
`define MRD_ROW_W 10
`define MRD_ROW_DEPTH 586

`endif

// ==== rtl/mrd_pkg.sv ====
`include "mrd_cfg.svh"

package mrd_pkg;

	// ------------------------------------------------------------
	// sample and bank types
	// ------------------------------------------------------------

	typedef struct packed {
		logic signed [`MRD_DATA_W-1:0] re;
		logic signed [`MRD_DATA_W-1:0] im;
	} cplx_t;

	// bank number of one lane, 7 marks a lane above the radix
	typedef logic [2:0] bank_idx_t;

	localparam bank_idx_t BANK_NONE = 3'd7;

	typedef struct packed {
		bank_idx_t               bank;
		logic [`MRD_ROW_W-1:0]   row;
	} lane_addr_t;

	// ------------------------------------------------------------
	// pipeline payloads
	// ------------------------------------------------------------

	// one butterfly read request, lane 0 in the low bits
	typedef struct packed {
		lane_addr_t [`MRD_NUM_LANES-1:0] lane;
		logic [2:0]                      radix;
		logic [`MRD_ADDR_W-1:0]          bfly;
	} bfly_req_t;

	// one butterfly worth of samples in lane order
	typedef struct packed {
		cplx_t [`MRD_NUM_LANES-1:0] lane;
		logic [2:0]                 radix;
		logic [`MRD_ADDR_W-1:0]     bfly;
	} rd_beat_t;

endpackage

// ==== rtl/mrd_div7.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module mrd_div7 (
	input  logic [`MRD_ADDR_W-1:0] dividend,
	output logic [`MRD_ROW_W-1:0]  quotient,
	output mrd_pkg::bank_idx_t     remainder
);

	// 1170/8192 lies just under 1/7
	// estimate is low by at most one over the 12-bit range
	localparam logic [10:0] RECIP = 11'd1170;
	localparam int unsigned SHIFT = 13;

	logic [`MRD_ADDR_W+10:0] product;
	logic [`MRD_ROW_W-1:0]   q_est;
	logic [`MRD_ADDR_W-1:0]  diff;
	logic [3:0]              r_est;
	logic [3:0]              r_fix;

	always_comb
	begin
		product = dividend * RECIP;
		q_est = product[SHIFT +: `MRD_ROW_W];
		// residue stays below 14, four bits are enough
		diff = dividend - q_est * 3'd7;
		r_est = diff[3:0];
		r_fix = r_est - 4'd7;
		// correction step when the estimate came out one short
		if (r_est >= 4'd7)
		begin
			quotient = q_est + 1'b1;
			remainder = r_fix[2:0];
		end
		else
		begin
			quotient = q_est;
			remainder = r_est[2:0];
		end
	end

endmodule

// ==== rtl/mrd_bfly_addr_gen.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module mrd_bfly_addr_gen (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic [2:0]             radix,
	input  logic [`MRD_ADDR_W-1:0] num_bfly,
	output logic                   busy,
	output logic                   req_valid,
	output mrd_pkg::bfly_req_t     req
);
	import mrd_pkg::*;

	logic                   run;
	logic [2:0]             drain;
	logic                   accept;
	logic                   last_bfly;
	logic [2:0]             radix_q;
	logic [`MRD_ADDR_W-1:0] nbfly_q;
	logic [`MRD_ADDR_W-1:0] bfly_cnt;

	logic [`MRD_ADDR_W-1:0] lane_addr [`MRD_NUM_LANES];
	logic [`MRD_ROW_W-1:0]  lane_row [`MRD_NUM_LANES];
	bank_idx_t              lane_bank [`MRD_NUM_LANES];

	// ------------------------------------------------------------
	// butterfly counter
	// ------------------------------------------------------------

	// busy also covers the three pipeline stages behind the counter
	assign busy = run | (|drain);
	assign accept = start & ~busy;
	assign last_bfly = (bfly_cnt == nbfly_q - 1'b1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			run <= 1'b0;
			drain <= '0;
			bfly_cnt <= '0;
			radix_q <= '0;
			nbfly_q <= '0;
		end
		else
		begin
			drain <= {drain[1:0], run};
			if (accept)
			begin
				run <= 1'b1;
				bfly_cnt <= '0;
				radix_q <= radix;
				nbfly_q <= num_bfly;
			end
			else if (run)
			begin
				if (last_bfly)
					run <= 1'b0;
				else
					bfly_cnt <= bfly_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// lane addresses b + k*M, split into bank and row
	// ------------------------------------------------------------

	for (genvar k = 0; k < `MRD_NUM_LANES; k++)
	begin : g_lane
		localparam logic [`MRD_ADDR_W-1:0] LANE_K = k;

		assign lane_addr[k] = bfly_cnt + LANE_K * nbfly_q;

		mrd_div7 i_div7 (
			.dividend  (lane_addr[k]),
			.quotient  (lane_row[k]),
			.remainder (lane_bank[k])
		);
	end

	// registered request
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			req_valid <= 1'b0;
		else
			req_valid <= run;
	end

	always_ff @(posedge clk)
	begin
		if (run)
		begin
			req.radix <= radix_q;
			req.bfly <= bfly_cnt;
			for (int k = 0; k < `MRD_NUM_LANES; k++)
			begin
				// lanes above the radix read nothing
				if (k < radix_q)
				begin
					req.lane[k].bank <= lane_bank[k];
					req.lane[k].row <= lane_row[k];
				end
				else
				begin
					req.lane[k].bank <= BANK_NONE;
					req.lane[k].row <= '0;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	a_start_args: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (radix >= 3'd2 && radix <= 3'd5 && num_bfly != '0))
		else $error("start with radix %0d and num_bfly %0d", radix, num_bfly);

	for (genvar k = 0; k < `MRD_NUM_LANES; k++)
	begin : g_row_chk
		a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
			(req_valid && req.lane[k].bank != BANK_NONE)
				|-> (req.lane[k].row < `MRD_ROW_DEPTH))
			else $error("lane %0d row %0d beyond bank depth", k, req.lane[k].row);
	end

endmodule

// ==== rtl/mrd_bank_mem.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module mrd_bank_mem #(
	parameter type payload_t = mrd_pkg::cplx_t
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              wr_en,
	input  logic [`MRD_ADDR_W-1:0]            wr_addr,
	input  payload_t                          wr_data,
	input  logic                              req_valid,
	input  mrd_pkg::bfly_req_t                req,
	output logic                              rd_valid,
	output mrd_pkg::bfly_req_t                rd_req,
	output payload_t [`MRD_NUM_BANKS-1:0]     bank_dout
);
	import mrd_pkg::*;

	logic [`MRD_ROW_W-1:0] wr_row;
	bank_idx_t             wr_bank;
	logic [`MRD_ROW_W-1:0] rd_row [`MRD_NUM_BANKS];

	// write address goes through the same bank mapping as the reads
	mrd_div7 i_wr_div7 (
		.dividend  (wr_addr),
		.quotient  (wr_row),
		.remainder (wr_bank)
	);

	// ------------------------------------------------------------
	// lane to bank routing
	// ------------------------------------------------------------

	// at most one lane names a bank, idle banks read row 0
	always_comb
	begin
		for (int j = 0; j < `MRD_NUM_BANKS; j++)
		begin
			rd_row[j] = '0;
			for (int k = 0; k < `MRD_NUM_LANES; k++)
			begin
				if (req.lane[k].bank == j)
					rd_row[j] = req.lane[k].row;
			end
		end
	end

	// ------------------------------------------------------------
	// banks
	// ------------------------------------------------------------

	for (genvar j = 0; j < `MRD_NUM_BANKS; j++)
	begin : g_bank
		payload_t mem [`MRD_ROW_DEPTH];
		payload_t dout_q;

		always_ff @(posedge clk)
		begin
			if (wr_en && wr_bank == j)
				mem[wr_row] <= wr_data;
			if (req_valid)
				dout_q <= mem[rd_row[j]];
		end

		assign bank_dout[j] = dout_q;
	end

	// request rides along with the read data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
			rd_req <= req;
	end

	// lanes of one butterfly must sit in different banks
	for (genvar a = 0; a < `MRD_NUM_LANES - 1; a++)
	begin : g_conf_a
		for (genvar b = a + 1; b < `MRD_NUM_LANES; b++)
		begin : g_conf_b
			a_no_conflict: assert property (@(posedge clk) disable iff (!rst_n)
				(req_valid && req.lane[a].bank != BANK_NONE)
					|-> (req.lane[a].bank != req.lane[b].bank))
				else $error("lanes %0d and %0d share bank %0d", a, b, req.lane[a].bank);
		end
	end

endmodule

// ==== rtl/mrd_lane_gather.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module mrd_lane_gather #(
	parameter type payload_t = mrd_pkg::cplx_t
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          rd_valid,
	input  mrd_pkg::bfly_req_t            rd_req,
	input  payload_t [`MRD_NUM_BANKS-1:0] bank_dout,
	output logic                          beat_valid,
	output mrd_pkg::rd_beat_t             beat,
	output logic                          stage_done
);
	import mrd_pkg::*;

	rd_beat_t  beat_d;
	bank_idx_t sel;

	// ------------------------------------------------------------
	// bank outputs back into lane order
	// ------------------------------------------------------------

	always_comb
	begin
		beat_d.radix = rd_req.radix;
		beat_d.bfly = rd_req.bfly;
		sel = BANK_NONE;
		for (int k = 0; k < `MRD_NUM_LANES; k++)
		begin
			sel = rd_req.lane[k].bank;
			// unused lane reads as zero
			if (sel == BANK_NONE)
				beat_d.lane[k] = '0;
			else
				beat_d.lane[k] = cplx_t'(bank_dout[sel]);
		end
	end

	// ------------------------------------------------------------
	// beat register
	// ------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			beat_valid <= 1'b0;
		else
			beat_valid <= rd_valid;
	end

	always_ff @(posedge clk)
	begin
		if (rd_valid)
			beat <= beat_d;
	end

	// reads of a stage are back to back, so the held beat is the
	// last one once rd_valid has dropped behind it
	// stages never abut, busy keeps a gap between them
	assign stage_done = beat_valid & ~rd_valid;

endmodule

// ==== rtl/mrd_stage_reader.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module mrd_stage_reader (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic [2:0]             radix,
	input  logic [`MRD_ADDR_W-1:0] num_bfly,
	input  logic                   wr_en,
	input  logic [`MRD_ADDR_W-1:0] wr_addr,
	input  mrd_pkg::cplx_t         wr_data,
	output logic                   busy,
	output logic                   beat_valid,
	output mrd_pkg::rd_beat_t      beat,
	output logic                   stage_done
);
	import mrd_pkg::*;

	logic                           req_valid;
	bfly_req_t                      req;
	logic                           rd_valid;
	bfly_req_t                      rd_req;
	cplx_t [`MRD_NUM_BANKS-1:0]     bank_dout;

	// ------------------------------------------------------------
	// address producer, banked buffer, lane reorder
	// ------------------------------------------------------------

	mrd_bfly_addr_gen i_addr_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.radix     (radix),
		.num_bfly  (num_bfly),
		.busy      (busy),
		.req_valid (req_valid),
		.req       (req)
	);

	mrd_bank_mem #(
		.payload_t (cplx_t)
	) i_bank_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.req_valid (req_valid),
		.req       (req),
		.rd_valid  (rd_valid),
		.rd_req    (rd_req),
		.bank_dout (bank_dout)
	);

	mrd_lane_gather #(
		.payload_t (cplx_t)
	) i_lane_gather (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_valid   (rd_valid),
		.rd_req     (rd_req),
		.bank_dout  (bank_dout),
		.beat_valid (beat_valid),
		.beat       (beat),
		.stage_done (stage_done)
	);

endmodule

// ==== test/tb_mrd_stage_reader.sv ====
`timescale 1ns/100ps
`include "mrd_cfg.svh"

module tb_mrd_stage_reader;
	import mrd_pkg::*;

	localparam int NUM_STAGES = 4;
	localparam int IDLE_CYCLES = 10;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	logic [2:0]             radix;
	logic [`MRD_ADDR_W-1:0] num_bfly;
	logic                   wr_en;
	logic [`MRD_ADDR_W-1:0] wr_addr;
	cplx_t                  wr_data;
	logic                   busy;
	logic                   beat_valid;
	rd_beat_t               beat;
	logic                   stage_done;

	cplx_t       model [1 << `MRD_ADDR_W];
	rd_beat_t    exp_beat;
	logic [31:0] lcg_state;
	int          cyc;
	int          cycle_limit;
	int          cur_radix;
	int          cur_nbfly;
	int          start_cyc;
	int          last_beat_cyc;
	int          beat_cnt;
	logic        stage_active;
	logic        done_pending;
	logic        stage_finished;

	mrd_stage_reader i_mrd_stage_reader (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.radix      (radix),
		.num_bfly   (num_bfly),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.busy       (busy),
		.beat_valid (beat_valid),
		.beat       (beat),
		.stage_done (stage_done)
	);

	always #4 clk = ~clk;

	// ------------------------------------------------------------
	// stage table and helpers
	// ------------------------------------------------------------

	function automatic int radix_of(input int i);
		case (i)
			0: return 2;
			1: return 3;
			2: return 4;
			default: return 5;
		endcase
	endfunction

	function automatic int nbfly_of(input int i);
		case (i)
			0: return 24;
			1: return 15;
			2: return 16;
			default: return 27;
		endcase
	endfunction

	// load, beats and pipeline slack of one stage
	function automatic int cycles_for(input int r, input int m);
		return r * m + m + 12;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_sample(output cplx_t s);
		lcg_state = lcg_next(lcg_state);
		s.re = lcg_state[31:14];
		lcg_state = lcg_next(lcg_state);
		s.im = lcg_state[31:14];
	endtask

	// lane k holds sample b + k*M
	// lanes above the radix stay zero
	function automatic rd_beat_t expected_beat(input int r, input int m, input int b);
		rd_beat_t e;
		e = '0;
		e.radix = r[2:0];
		e.bfly = b[`MRD_ADDR_W-1:0];
		for (int k = 0; k < `MRD_NUM_LANES; k++)
		begin
			if (k < r)
				e.lane[k] = model[b + k * m];
		end
		return e;
	endfunction

	task automatic check_equal(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at time %0t", why, $time);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic load_samples(input int n);
		cplx_t s;
		for (int a = 0; a < n; a++)
		begin
			@(posedge clk);
			#1;
			draw_sample(s);
			model[a] = s;
			wr_en = 1'b1;
			wr_addr = a[`MRD_ADDR_W-1:0];
			wr_data = s;
		end
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic run_stage(input int r, input int m);
		load_samples(r * m);
		@(posedge clk);
		#1;
		cur_radix = r;
		cur_nbfly = m;
		beat_cnt = 0;
		stage_finished = 1'b0;
		stage_active = 1'b1;
		start_cyc = cyc;
		start = 1'b1;
		radix = r[2:0];
		num_bfly = m[`MRD_ADDR_W-1:0];
		@(posedge clk);
		#1;
		start = 1'b0;
		check_equal("busy", busy, 1'b1);
		// stray start in the middle of the stage is ignored
		repeat (2) @(posedge clk);
		#1;
		check_equal("busy", busy, 1'b1);
		start = 1'b1;
		radix = 3'd3;
		num_bfly = 7;
		@(posedge clk);
		#1;
		start = 1'b0;
		while (!stage_finished)
			@(posedge clk);
	endtask

	// ------------------------------------------------------------
	// cycle counter and timeout
	// ------------------------------------------------------------

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit)
			abort_run("timeout, the stages did not finish within the cycle limit");
	end

	// ------------------------------------------------------------
	// beat checker
	// ------------------------------------------------------------

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (done_pending)
			begin
				check_equal("busy", busy, 1'b0);
				done_pending = 1'b0;
				stage_active = 1'b0;
				stage_finished = 1'b1;
			end
			if (beat_valid && (!stage_active || beat_cnt >= cur_nbfly))
				abort_run("beat_valid was high while no beat was expected");
			else if (beat_valid)
			begin
				if (beat_cnt == 0)
					check_equal("first beat latency", cyc - start_cyc, 4);
				else
					check_equal("beat spacing", cyc - last_beat_cyc, 1);
				// busy holds through the last beat
				check_equal("busy", busy, 1'b1);
				exp_beat = expected_beat(cur_radix, cur_nbfly, beat_cnt);
				check_equal("beat.radix", beat.radix, exp_beat.radix);
				check_equal("beat.bfly", beat.bfly, exp_beat.bfly);
				for (int k = 0; k < `MRD_NUM_LANES; k++)
				begin
					check_equal($sformatf("beat.lane[%0d].re", k), beat.lane[k].re,
						exp_beat.lane[k].re);
					check_equal($sformatf("beat.lane[%0d].im", k), beat.lane[k].im,
						exp_beat.lane[k].im);
				end
				check_equal("stage_done", stage_done, beat_cnt == cur_nbfly - 1);
				last_beat_cyc = cyc;
				beat_cnt++;
				if (stage_done)
					done_pending = 1'b1;
			end
			else
				check_equal("stage_done", stage_done, 1'b0);
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial
	begin
		int total;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		radix = '0;
		num_bfly = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		lcg_state = 32'd66;
		cyc = 0;
		cur_radix = 0;
		cur_nbfly = 0;
		start_cyc = 0;
		last_beat_cyc = 0;
		beat_cnt = 0;
		stage_active = 1'b0;
		done_pending = 1'b0;
		stage_finished = 1'b0;
		total = 5 + 2 * IDLE_CYCLES;
		for (int i = 0; i < NUM_STAGES; i++)
			total += cycles_for(radix_of(i), nbfly_of(i));
		cycle_limit = 2 * total + 100;

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet outputs before the first start
		repeat (IDLE_CYCLES)
		begin
			@(negedge clk);
			check_equal("busy", busy, 1'b0);
			check_equal("beat_valid", beat_valid, 1'b0);
			check_equal("stage_done", stage_done, 1'b0);
		end

		for (int i = 0; i < NUM_STAGES; i++)
			run_stage(radix_of(i), nbfly_of(i));

		repeat (IDLE_CYCLES) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
rtl/mrd_pkg.sv
rtl/mrd_div7.sv
rtl/mrd_bfly_addr_gen.sv
rtl/mrd_bank_mem.sv
rtl/mrd_lane_gather.sv
rtl/mrd_stage_reader.sv
test/tb_mrd_stage_reader.sv

// ==== Bender.yml ====
package:
  name: mrd_stage_reader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mrd_pkg.sv
      - rtl/mrd_div7.sv
      - rtl/mrd_bfly_addr_gen.sv
      - rtl/mrd_bank_mem.sv
      - rtl/mrd_lane_gather.sv
      - rtl/mrd_stage_reader.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_mrd_stage_reader.sv
